// File: Bender.yml
package:
  name: rtx_scene

sources:
  # package first, then leaf modules, then the top level
  - files:
      - source/rtx_pkg.sv
      - source/uart_receive.sv
      - source/uart_memflash.sv
      - source/scene_buffer.sv
      - source/scene_control.sv
      - source/rtx_scene_top.sv
  - target: simulation
    files:
      - sim/tb_rtx_scene.sv

// File: list.f
source/rtx_pkg.sv
source/uart_receive.sv
source/uart_memflash.sv
source/scene_buffer.sv
source/scene_control.sv
source/rtx_scene_top.sv
sim/tb_rtx_scene.sv

// File: sim/tb_rtx_scene.sv
`default_nettype none

module tb_rtx_scene;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_HZ       = 100_000_000;
  localparam int BAUD_RATE    = 10_000_000;
  localparam int MAX_NUM_OBJS = 32;
  localparam int H_RES        = 1280;
  localparam int V_RES        = 720;
  localparam int BIT_CYCLES   = CLK_HZ / BAUD_RATE;
  // camera 4x7, objects 5x12, counts 8, mid-frame write 2
  localparam int TOTAL_BYTES  = 4 * 7 + 5 * 12 + 8 + 2;
  localparam int TIMEOUT_CYC  = TOTAL_BYTES * 10 * BIT_CYCLES * 2 + 2000;

  logic                            clk_rtx;
  logic                            sys_rst;
  logic                            rxd;
  logic [$clog2(MAX_NUM_OBJS)-1:0] obj_rd_idx;
  logic [10:0]                     pixel_h;
  logic [9:0]                      pixel_v;
  logic                            ray_done;
  logic                            overwrite_force;
  logic                            mem_busy;
  logic                            flash_active;
  rtx_pkg::object_t                obj_rd;
  rtx_pkg::camera_t                camera;
  logic [$clog2(MAX_NUM_OBJS):0]   num_objs;
  logic [7:0]                      max_bounces;
  logic                            overwrite;
  logic                            engine_rst;

  // reference model of what the DUT should hold
  rtx_pkg::camera_t exp_cam;
  rtx_pkg::object_t exp_mem [MAX_NUM_OBJS];
  logic [7:0]       exp_num;
  logic [7:0]       exp_bounce;

  int errors;
  int checks;
  int err_mark;
  int cycles;

  rtx_scene_top #(
    .CLK_HZ      (CLK_HZ),
    .BAUD_RATE   (BAUD_RATE),
    .MAX_NUM_OBJS(MAX_NUM_OBJS),
    .H_RES       (H_RES),
    .V_RES       (V_RES)
  ) u_rtx_scene_top (
    .clk_rtx        (clk_rtx),
    .sys_rst        (sys_rst),
    .rxd            (rxd),
    .obj_rd_idx     (obj_rd_idx),
    .pixel_h        (pixel_h),
    .pixel_v        (pixel_v),
    .ray_done       (ray_done),
    .overwrite_force(overwrite_force),
    .mem_busy       (mem_busy),
    .flash_active   (flash_active),
    .obj_rd         (obj_rd),
    .camera         (camera),
    .num_objs       (num_objs),
    .max_bounces    (max_bounces),
    .overwrite      (overwrite),
    .engine_rst     (engine_rst)
  );

  initial begin
    clk_rtx = 1'b0;
    forever #5 clk_rtx = ~clk_rtx;
  end

  // run limit from the serial traffic of all tests
  always @(posedge clk_rtx) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYC) begin
      $display("timeout after %0d cycles, a test did not finish", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // inputs change 1 ns after the edge, outputs read there too
  task automatic step();
    @(posedge clk_rtx);
    #1;
  endtask

  task automatic check_camera(input string name, input rtx_pkg::camera_t exp,
                              input rtx_pkg::camera_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_object(input string name, input rtx_pkg::object_t exp,
                              input rtx_pkg::object_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input logic [7:0] exp,
                             input logic [7:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // compare every config output against the model
  task automatic check_config();
    check_camera("camera", exp_cam, camera);
    check_count("num_objs", exp_num, 8'(num_objs));
    check_count("max_bounces", exp_bounce, max_bounces);
  endtask

  task automatic finish_test(input string name);
    $display("test %s done, %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // 8N1, lsb first, idle high
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rxd = frame[i];
      repeat (BIT_CYCLES) step();
    end
  endtask

  // frame done once flash_active drops, registers one cycle later
  task automatic wait_write_done();
    while (flash_active) step();
    step();
  endtask

  task automatic send_config(input logic [2:0] sel, input logic [47:0] pay,
                             input int nbytes);
    send_byte({5'b10000, sel});
    if (nbytes > 0) check_flag("flash_active", 1'b1, flash_active);
    for (int i = nbytes - 1; i >= 0; i--) send_byte(pay[i*8 +: 8]);
    wait_write_done();
  endtask

  task automatic send_object(input logic [6:0] idx, input rtx_pkg::object_t obj);
    logic [87:0] bits;
    bits = obj;
    send_byte({1'b0, idx});
    check_flag("flash_active", 1'b1, flash_active);
    // msb first on the wire
    for (int i = 10; i >= 0; i--) send_byte(bits[i*8 +: 8]);
    wait_write_done();
    if (idx < MAX_NUM_OBJS) exp_mem[idx] = obj;
  endtask

  function automatic rtx_pkg::vec3_t rand_vec();
    rtx_pkg::vec3_t v;
    v.x = rtx_pkg::fp_t'($urandom);
    v.y = rtx_pkg::fp_t'($urandom);
    v.z = rtx_pkg::fp_t'($urandom);
    return v;
  endfunction

  function automatic rtx_pkg::object_t rand_object();
    rtx_pkg::object_t o;
    o.center   = rand_vec();
    o.radius   = rtx_pkg::fp_t'($urandom);
    o.color    = 16'($urandom);
    o.material = rtx_pkg::material_e'(8'($urandom_range(0, 3)));
    return o;
  endfunction

  // one ray_done strobe at a given pixel, overwrite read after the edge
  task automatic pulse_ray(input int h, input int v);
    pixel_h  = 11'(h);
    pixel_v  = 10'(v);
    ray_done = 1'b1;
    step();
    ray_done = 1'b0;
  endtask

  task automatic test_reset_defaults();
    check_config();
    check_flag("overwrite", 1'b0, overwrite);
    check_flag("flash_active", 1'b0, flash_active);
    // engine held while memory reports busy
    repeat (4) begin
      step();
      check_flag("engine_rst", 1'b1, engine_rst);
    end
    mem_busy = 1'b0;
    step();
    check_flag("engine_rst", 1'b0, engine_rst);
    finish_test("reset_defaults");
  endtask

  task automatic test_camera();
    rtx_pkg::vec3_t v;
    for (int s = 0; s < 4; s++) begin
      v = rand_vec();
      case (s)
        0: exp_cam.origin  = v;
        1: exp_cam.forward = v;
        2: exp_cam.right   = v;
        default: exp_cam.up = v;
      endcase
      send_config(3'(s), v, 6);
      check_config();
    end
    finish_test("camera");
  endtask

  task automatic test_objects();
    send_object(7'd0, rand_object());
    send_object(7'd5, rand_object());
    send_object(7'd17, rand_object());
    send_object(7'd31, rand_object());
    // out of range, model stays as it is
    send_object(7'd40, rand_object());
    for (int i = 0; i < MAX_NUM_OBJS; i++) begin
      obj_rd_idx = 5'(i);
      step();
      check_object($sformatf("obj_rd[%0d]", i), exp_mem[i], obj_rd);
    end
    finish_test("objects");
  endtask

  task automatic test_counts();
    send_config(3'd4, 48'd7, 1);
    exp_num = 8'd7;
    check_config();
    send_config(3'd4, 48'd200, 1);
    // saturates at buffer size
    exp_num = 8'(MAX_NUM_OBJS);
    check_config();
    send_config(3'd5, 48'd9, 1);
    exp_bounce = 8'd9;
    check_config();
    // unused selects carry nothing
    send_config(3'd6, 48'd0, 0);
    send_config(3'd7, 48'd0, 0);
    check_config();
    finish_test("counts");
  endtask

  task automatic test_overwrite();
    // earlier tests wrote, so the first frame end replaces
    pulse_ray(H_RES - 1, V_RES - 1);
    check_flag("overwrite", 1'b1, overwrite);
    pulse_ray(H_RES - 1, V_RES - 1);
    check_flag("overwrite", 1'b0, overwrite);
    send_config(3'd5, 48'd4, 1);
    exp_bounce = 8'd4;
    check_config();
    pulse_ray(H_RES - 1, V_RES - 1);
    check_flag("overwrite", 1'b1, overwrite);
    pulse_ray(H_RES - 1, V_RES - 1);
    check_flag("overwrite", 1'b0, overwrite);
    overwrite_force = 1'b1;
    pulse_ray(H_RES - 1, V_RES - 1);
    check_flag("overwrite", 1'b1, overwrite);
    overwrite_force = 1'b0;
    // not the last pixel, held at 1
    pulse_ray(5, V_RES - 1);
    check_flag("overwrite", 1'b1, overwrite);
    pulse_ray(H_RES - 1, V_RES - 1);
    check_flag("overwrite", 1'b0, overwrite);
    overwrite_force = 1'b1;
    pulse_ray(H_RES - 1, 3);
    check_flag("overwrite", 1'b0, overwrite);
    overwrite_force = 1'b0;
    finish_test("overwrite");
  endtask

  initial begin
    void'($urandom(32'h2fe8));
    errors          = 0;
    checks          = 0;
    err_mark        = 0;
    sys_rst         = 1'b1;
    rxd             = 1'b1;
    obj_rd_idx      = '0;
    pixel_h         = '0;
    pixel_v         = '0;
    ray_done        = 1'b0;
    overwrite_force = 1'b0;
    mem_busy        = 1'b1;
    // defaults after reset
    exp_cam            = '0;
    exp_cam.forward.z  = rtx_pkg::FP_HALF_SCREEN_WIDTH;
    exp_cam.right.x    = rtx_pkg::FP_ONE;
    exp_cam.up.y       = rtx_pkg::FP_ONE;
    exp_num            = 8'd16;
    exp_bounce         = 8'd3;
    for (int i = 0; i < MAX_NUM_OBJS; i++) exp_mem[i] = '0;
    repeat (16) step();
    sys_rst = 1'b0;
    step();
    test_reset_defaults();
    test_camera();
    test_objects();
    test_counts();
    test_overwrite();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/rtx_pkg.sv
`default_nettype none

package rtx_pkg;

  // signed Q8.8, 8 integer bits and 8 fraction bits
  typedef logic signed [15:0] fp_t;

  // 3-vector, x in the top bits so the wire order is x, y, z
  typedef struct packed {
    fp_t x;
    fp_t y;
    fp_t z;
  } vec3_t;

  // camera basis, forward is scaled to the focal distance
  typedef struct packed {
    vec3_t origin;
    vec3_t forward;
    vec3_t right;
    vec3_t up;
  } camera_t;

  // surface kind, one byte on the wire
  typedef enum logic [7:0] {
    diffuse = 8'd0,
    mirror  = 8'd1,
    glass   = 8'd2,
    emitter = 8'd3
  } material_e;

  // sphere as stored in the scene buffer
  typedef struct packed {
    vec3_t       center;
    fp_t         radius;
    // rgb565
    logic [15:0] color;
    material_e   material;
  } object_t;

  // low three bits of a config command byte
  typedef enum logic [2:0] {
    cam_origin  = 3'd0,
    cam_forward = 3'd1,
    cam_right   = 3'd2,
    cam_up      = 3'd3,
    num_objs    = 3'd4,
    max_bounces = 3'd5
  } flash_sel_e;

  // one decoded write, payload right-aligned
  typedef struct packed {
    logic                        is_cfg;
    logic [6:0]                  obj_idx;
    flash_sel_e                  sel;
    logic [$bits(object_t)-1:0]  payload;
  } flash_write_t;

  localparam fp_t FP_ONE = 16'h0100;
  // half of 1280, clamped to the top of the Q8.8 range
  localparam fp_t FP_HALF_SCREEN_WIDTH = 16'h7fff;

  localparam int DEFAULT_NUM_OBJS    = 16;
  localparam int DEFAULT_MAX_BOUNCES = 3;

  // payload byte counts on the serial line
  localparam int OBJ_BYTES = $bits(object_t) / 8;
  localparam int VEC_BYTES = $bits(vec3_t) / 8;

  // camera after reset, looking down +z
  localparam camera_t CAM_DEFAULT = '{
    origin:  '{x: '0, y: '0, z: '0},
    forward: '{x: '0, y: '0, z: FP_HALF_SCREEN_WIDTH},
    right:   '{x: FP_ONE, y: '0, z: '0},
    up:      '{x: '0, y: FP_ONE, z: '0}
  };

endpackage

`default_nettype wire

// File: source/rtx_scene_top.sv
`default_nettype none

module rtx_scene_top #(
  parameter int CLK_HZ       = 100_000_000,
  parameter int BAUD_RATE    = 115_200,
  parameter int MAX_NUM_OBJS = 32,
  parameter int H_RES        = 1280,
  parameter int V_RES        = 720
) (
  input  wire                              clk_rtx,
  input  wire                              sys_rst,
  input  wire                              rxd,
  input  wire  [$clog2(MAX_NUM_OBJS)-1:0]  obj_rd_idx,
  input  wire  [10:0]                      pixel_h,
  input  wire  [9:0]                       pixel_v,
  input  wire                              ray_done,
  input  wire                              overwrite_force,
  input  wire                              mem_busy,
  output logic                             flash_active,
  output rtx_pkg::object_t                 obj_rd,
  output rtx_pkg::camera_t                 camera,
  output logic [$clog2(MAX_NUM_OBJS):0]    num_objs,
  output logic [7:0]                       max_bounces,
  output logic                             overwrite,
  output logic                             engine_rst
);

  // serial byte stream
  logic                  rx_valid;
  logic [7:0]            rx_byte;
  // decoded write, fanned out to buffer and control
  logic                  flash_wen;
  rtx_pkg::flash_write_t flash_write;

  uart_receive #(
    .CLK_HZ   (CLK_HZ),
    .BAUD_RATE(BAUD_RATE)
  ) u_uart_receive (
    .clk_rtx (clk_rtx),
    .sys_rst (sys_rst),
    .rxd     (rxd),
    .rx_valid(rx_valid),
    .rx_byte (rx_byte)
  );

  uart_memflash u_uart_memflash (
    .clk_rtx     (clk_rtx),
    .sys_rst     (sys_rst),
    .rx_valid    (rx_valid),
    .rx_byte     (rx_byte),
    .flash_active(flash_active),
    .flash_wen   (flash_wen),
    .flash_write (flash_write)
  );

  // object side of the write
  scene_buffer #(
    .MAX_NUM_OBJS(MAX_NUM_OBJS)
  ) u_scene_buffer (
    .clk_rtx    (clk_rtx),
    .sys_rst    (sys_rst),
    .flash_wen  (flash_wen),
    .flash_write(flash_write),
    .obj_rd_idx (obj_rd_idx),
    .obj_rd     (obj_rd)
  );

  // config side, overwrite latch and memory gate
  scene_control #(
    .MAX_NUM_OBJS(MAX_NUM_OBJS),
    .H_RES       (H_RES),
    .V_RES       (V_RES)
  ) u_scene_control (
    .clk_rtx        (clk_rtx),
    .sys_rst        (sys_rst),
    .flash_wen      (flash_wen),
    .flash_write    (flash_write),
    .pixel_h        (pixel_h),
    .pixel_v        (pixel_v),
    .ray_done       (ray_done),
    .overwrite_force(overwrite_force),
    .mem_busy       (mem_busy),
    .camera         (camera),
    .num_objs       (num_objs),
    .max_bounces    (max_bounces),
    .overwrite      (overwrite),
    .engine_rst     (engine_rst)
  );

endmodule

`default_nettype wire

// File: source/scene_buffer.sv
`default_nettype none

module scene_buffer #(
  parameter int MAX_NUM_OBJS = 32
) (
  input  wire                              clk_rtx,
  input  wire                              sys_rst,
  input  wire                              flash_wen,
  input  wire rtx_pkg::flash_write_t       flash_write,
  input  wire  [$clog2(MAX_NUM_OBJS)-1:0]  obj_rd_idx,
  output rtx_pkg::object_t                 obj_rd
);

  localparam int IDX_W = $clog2(MAX_NUM_OBJS);

  rtx_pkg::object_t mem [MAX_NUM_OBJS];

  logic [IDX_W-1:0] clr_idx;
  logic             clr_busy;
  logic             obj_wen;
  logic [IDX_W-1:0] wr_idx;

  // object writes only, out-of-range index dropped
  assign obj_wen = flash_wen && !flash_write.is_cfg
                   && (int'(flash_write.obj_idx) < MAX_NUM_OBJS);
  assign wr_idx  = flash_write.obj_idx[IDX_W-1:0];

  // walk every entry once after reset
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      clr_busy <= 1'b1;
      clr_idx  <= '0;
    end else if (clr_busy) begin
      clr_idx <= clr_idx + 1'b1;
      if (clr_idx == IDX_W'(MAX_NUM_OBJS - 1)) begin
        clr_busy <= 1'b0;
      end
    end
  end

  // single write port, clear wins
  always_ff @(posedge clk_rtx) begin
    if (clr_busy) begin
      mem[clr_idx] <= '0;
    end else if (obj_wen) begin
      mem[wr_idx] <= flash_write.payload;
    end
  end

  // registered engine read, one cycle after the index
  always_ff @(posedge clk_rtx) begin
    obj_rd <= mem[obj_rd_idx];
  end

endmodule

`default_nettype wire

// File: source/scene_control.sv
`default_nettype none

module scene_control #(
  parameter int MAX_NUM_OBJS = 32,
  parameter int H_RES        = 1280,
  parameter int V_RES        = 720
) (
  input  wire                              clk_rtx,
  input  wire                              sys_rst,
  input  wire                              flash_wen,
  input  wire rtx_pkg::flash_write_t       flash_write,
  input  wire  [10:0]                      pixel_h,
  input  wire  [9:0]                       pixel_v,
  input  wire                              ray_done,
  input  wire                              overwrite_force,
  input  wire                              mem_busy,
  output rtx_pkg::camera_t                 camera,
  output logic [$clog2(MAX_NUM_OBJS):0]    num_objs,
  output logic [7:0]                       max_bounces,
  output logic                             overwrite,
  output logic                             engine_rst
);

  localparam int NUM_W = $clog2(MAX_NUM_OBJS) + 1;

  logic              cfg_wen;
  rtx_pkg::vec3_t    cfg_vec;
  logic [7:0]        cfg_byte;
  logic [NUM_W-1:0]  objs_sat;
  logic              last_pixel;
  logic              scene_changed;
  logic              mem_ready;

  assign cfg_wen  = flash_wen && flash_write.is_cfg;
  // vec payloads are 6 bytes, counts 1 byte, both right-aligned
  assign cfg_vec  = flash_write.payload[$bits(rtx_pkg::vec3_t)-1:0];
  assign cfg_byte = flash_write.payload[7:0];

  // clamp object count to the buffer size
  assign objs_sat = (int'(cfg_byte) > MAX_NUM_OBJS) ? NUM_W'(MAX_NUM_OBJS)
                                                    : NUM_W'(cfg_byte);

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      camera      <= rtx_pkg::CAM_DEFAULT;
      num_objs    <= NUM_W'(rtx_pkg::DEFAULT_NUM_OBJS);
      max_bounces <= 8'(rtx_pkg::DEFAULT_MAX_BOUNCES);
    end else if (cfg_wen) begin
      case (flash_write.sel)
        rtx_pkg::cam_origin:  camera.origin  <= cfg_vec;
        rtx_pkg::cam_forward: camera.forward <= cfg_vec;
        rtx_pkg::cam_right:   camera.right   <= cfg_vec;
        rtx_pkg::cam_up:      camera.up      <= cfg_vec;
        rtx_pkg::num_objs:    num_objs       <= objs_sat;
        rtx_pkg::max_bounces: max_bounces    <= cfg_byte;
        default: ;
      endcase
    end
  end

  // bottom-right pixel closes the frame
  assign last_pixel = ray_done
                      && (pixel_h == 11'(H_RES - 1))
                      && (pixel_v == 10'(V_RES - 1));

  // overwrite held for a whole frame, blend otherwise
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      overwrite     <= 1'b0;
      scene_changed <= 1'b0;
    end else if (last_pixel) begin
      // a write landing on the last pixel still counts
      overwrite     <= overwrite_force | scene_changed | flash_wen;
      scene_changed <= 1'b0;
    end else if (flash_wen) begin
      scene_changed <= 1'b1;
    end
  end

  // sticky once external memory has come up
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= mem_ready | !mem_busy;
    end
  end

  // engine held until memory is up
  assign engine_rst = sys_rst | !mem_ready;

endmodule

`default_nettype wire

// File: source/uart_memflash.sv
`default_nettype none

module uart_memflash (
  input  wire                   clk_rtx,
  input  wire                   sys_rst,
  input  wire                   rx_valid,
  input  wire  [7:0]            rx_byte,
  output logic                  flash_active,
  output logic                  flash_wen,
  output rtx_pkg::flash_write_t flash_write
);

  localparam int PAY_BITS = $bits(rtx_pkg::object_t);

  typedef enum logic [1:0] {wait_cmd, payload, commit} flash_state_e;

  flash_state_e        state;
  logic [7:0]          cmd;
  logic [3:0]          bytes_left;
  logic [3:0]          cmd_len;
  logic [PAY_BITS-1:0] pay_shift;

  // payload bytes that follow a command byte
  function automatic logic [3:0] payload_len(input logic [7:0] c);
    logic [3:0] len;
    if (!c[7]) begin
      len = 4'(rtx_pkg::OBJ_BYTES);
    end else begin
      case (c[2:0])
        rtx_pkg::cam_origin,
        rtx_pkg::cam_forward,
        rtx_pkg::cam_right,
        rtx_pkg::cam_up:        len = 4'(rtx_pkg::VEC_BYTES);
        rtx_pkg::num_objs,
        rtx_pkg::max_bounces:   len = 4'd1;
        // selects 6 and 7, nothing follows
        default:                len = 4'd0;
      endcase
    end
    return len;
  endfunction

  assign cmd_len = payload_len(rx_byte);

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      state        <= wait_cmd;
      flash_active <= 1'b0;
      flash_wen    <= 1'b0;
      bytes_left   <= '0;
    end else begin
      case (state)
        wait_cmd: begin
          if (rx_valid) begin
            flash_active <= 1'b1;
            bytes_left   <= cmd_len;
            // empty command goes straight to commit with no write
            state <= (cmd_len == 4'd0) ? commit : payload;
          end
        end
        payload: begin
          if (rx_valid) begin
            bytes_left <= bytes_left - 4'd1;
            if (bytes_left == 4'd1) begin
              state     <= commit;
              flash_wen <= 1'b1;
            end
          end
        end
        commit: begin
          // single-cycle write strobe
          flash_wen    <= 1'b0;
          flash_active <= 1'b0;
          state        <= wait_cmd;
        end
        default: state <= wait_cmd;
      endcase
    end
  end

  // command latch and msb-first payload shifter
  always_ff @(posedge clk_rtx) begin
    if (state == wait_cmd && rx_valid) begin
      cmd       <= rx_byte;
      // short payloads stay zero-extended
      pay_shift <= '0;
    end else if (state == payload && rx_valid) begin
      pay_shift <= {pay_shift[PAY_BITS-9:0], rx_byte};
    end
  end

  // decode straight off the latched command
  always_comb begin
    flash_write.is_cfg  = cmd[7];
    flash_write.obj_idx = cmd[6:0];
    flash_write.sel     = rtx_pkg::flash_sel_e'(cmd[2:0]);
    flash_write.payload = pay_shift;
  end

endmodule

`default_nettype wire

// File: source/uart_receive.sv
`default_nettype none

module uart_receive #(
  parameter int CLK_HZ    = 100_000_000,
  parameter int BAUD_RATE = 115_200
) (
  input  wire        clk_rtx,
  input  wire        sys_rst,
  input  wire        rxd,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  localparam int BIT_CYCLES = CLK_HZ / BAUD_RATE;
  localparam int CNT_W      = $clog2(BIT_CYCLES + 1);
  // last count of a full bit and of half a bit
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(BIT_CYCLES - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(BIT_CYCLES / 2 - 1);

  typedef enum logic [1:0] {idle, start, data, stop} rx_state_e;

  rx_state_e        state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;
  logic             rxd_meta;
  logic             rxd_sync;
  logic             rxd_prev;
  logic             bit_tick;

  // two-flop synchronizer, plus one more for edge detect
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  // mid-bit sample point once the start bit is centered
  assign bit_tick = (cnt == BIT_LAST);

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      state    <= idle;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        idle: begin
          cnt     <= '0;
          bit_idx <= '0;
          // falling edge on an idle-high line
          if (rxd_prev && !rxd_sync) begin
            state <= start;
          end
        end
        start: begin
          if (cnt == HALF_LAST) begin
            cnt <= '0;
            // glitch, line went back high
            state <= rxd_sync ? idle : data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        data: begin
          if (bit_tick) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= stop;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        stop: begin
          if (bit_tick) begin
            state <= idle;
            // bad stop bit drops the byte
            rx_valid <= rxd_sync;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // lsb first on the line
  always_ff @(posedge clk_rtx) begin
    if (state == data && bit_tick) begin
      shift <= {rxd_sync, shift[7:1]};
    end
    if (state == stop && bit_tick) begin
      rx_byte <= shift;
    end
  end

endmodule

`default_nettype wire
